// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := ex_stage_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "test failed, see $(LOG)"; exit 1; \
	else \
	  echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/ex_stage_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_assertions (
  input wire                      clk,
  input wire                      rst_i,
  input wire                      stall_i,
  input wire                      mem_stall_i,
  input wire                      idex_valid_i,
  input wire exu_pkg::redirect_t  redirect_i,
  input wire                      result_valid_i,
  input wire exu_pkg::ex_result_t result_i
);

  // id/ex is empty and nothing is busy from the second reset edge on
  stall_in_reset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !stall_i)
    else $error("stall_o high during reset");

  // the offer that meets an unheld redirect never reaches id/ex
  redirect_flush: assert property (
    @(posedge clk) disable iff (rst_i) redirect_i.valid && !stall_i |=> !idex_valid_i)
    else $error("instruction offered with a redirect was not dropped");

  // ex/mem holds its slot while memory stalls
  result_held: assert property (
    @(posedge clk) disable iff (rst_i)
    result_valid_i && mem_stall_i |=> result_valid_i && $stable(result_i))
    else $error("result changed under mem_stall_i");

endmodule

`default_nettype wire

// File: bench/ex_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module ex_stage_tb;
  import exu_pkg::*;

  localparam int num_instr = 600;

  logic        clk;
  logic        rst;
  logic        issue_valid;
  issue_t      issue;
  logic        mem_stall;
  logic        stall;
  logic        result_valid;
  ex_result_t  result;
  redirect_t   redirect;
  bpu_update_t bpu;

  logic [31:0] rng_state = 32'd24;
  ex_result_t  exp_q[$];          // results still owed in issue order
  issue_t      idex_m;            // model of the id/ex slot
  logic        idex_valid_m;
  int          md_left;           // mul/div cycles still to run
  logic        last_mem_stall;
  logic        held;              // stalled offer driven again
  int          accepted;
  int          cycles;

  ex_stage_top dut0 (
    .clk            (clk),
    .rst_i          (rst),
    .issue_valid_i  (issue_valid),
    .issue_i        (issue),
    .mem_stall_i    (mem_stall),
    .stall_o        (stall),
    .result_valid_o (result_valid),
    .result_o       (result),
    .redirect_o     (redirect),
    .bpu_o          (bpu)
  );

  bind ex_stage_top ex_stage_assertions u_assertions (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_o),
    .mem_stall_i    (mem_stall_i),
    .idex_valid_i   (idex_valid),
    .redirect_i     (redirect_o),
    .result_valid_i (result_valid_o),
    .result_i       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // corner values for divide and compare
  function automatic logic [31:0] pick_data();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0:    return 32'h0;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'hffff_ffff;
      default: return next_rand();
    endcase
  endfunction

  function automatic logic is_muldiv(issue_t i);
    return (i.exc_op == exc_opreg) && (i.alu_op >= alu_mul);
  endfunction

  function automatic issue_t new_instr(issue_t prev);
    issue_t      i;
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    i.pc          = {r[31:2], 2'b00};
    i.rd          = s[4:0];
    i.csr_addr    = s[16:5];
    i.csr_use_imm = s[17];
    i.pdt_taken   = s[18];
    i.rs1         = pick_data();
    i.rs2         = (s[20:19] == 2'd0) ? i.rs1 : pick_data();
    i.csr_old     = next_rand();
    i.alu_op      = alu_add;
    i.csr_op      = csr_none;
    r = next_rand();
    i.imm = {{20{r[11]}}, r[11:0]};
    if (r[30:28] == 3'd0) begin  // about one in eight
      i.exc_op = exc_opreg;
      i.alu_op = alu_op_e'(5'(16 + r[14:12]));
    end else begin
      i.exc_op = exc_op_e'(4'(1 + r[27:16] % 12'd10));
      case (i.exc_op)
        exc_lui, exc_auipc: i.imm = next_rand();
        exc_branch: i.alu_op = alu_op_e'(5'(10 + s[23:21] % 3'd6));
        exc_opimm, exc_opreg: i.alu_op = alu_op_e'(5'(s[27:24] % 4'd10));
        exc_csr: i.csr_op = csr_op_e'(2'(1 + s[23:21] % 3'd3));
        default: ;
      endcase
    end
    // same op and operands back to back would reuse the finished result
    if (is_muldiv(i) && is_muldiv(prev) && i.alu_op == prev.alu_op &&
        i.rs1 == prev.rs1 && i.rs2 == prev.rs2) begin
      i.rs1[0] = ~i.rs1[0];
    end
    return i;
  endfunction

  function automatic logic cond_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_beq:  return a == b;
      alu_bne:  return a != b;
      alu_blt:  return $signed(a) < $signed(b);
      alu_bge:  return $signed(a) >= $signed(b);
      alu_bltu: return a < b;
      alu_bgeu: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] p;
    logic        ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);  // signed overflow
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return {31'b0, $signed(a) < $signed(b)};
      alu_sltu: return {31'b0, a < b};
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return 32'($signed(a) >>> b[4:0]);
      alu_or:   return a | b;
      alu_and:  return a & b;
      alu_mul: begin
        p = {32'b0, a} * {32'b0, b};
        return p[31:0];
      end
      alu_mulh: begin
        p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        return p[63:32];
      end
      alu_mulhsu: begin
        p = {{32{a[31]}}, a} * {32'b0, b};
        return p[63:32];
      end
      alu_mulhu: begin
        p = {32'b0, a} * {32'b0, b};
        return p[63:32];
      end
      alu_div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'($signed(a) / $signed(b)));
      alu_divu: return (b == 0) ? 32'hffff_ffff : a / b;
      alu_rem:  return (b == 0) ? a : (ovf ? 32'h0 : 32'($signed(a) % $signed(b)));
      alu_remu: return (b == 0) ? a : a % b;
      default:  return {31'b0, cond_model(op, a, b)};  // branch compares
    endcase
  endfunction

  function automatic ex_result_t expected_result(issue_t i);
    ex_result_t  e;
    logic [31:0] up;
    logic [31:0] src;
    up           = {i.imm[31:12], 12'b0};
    e.pc         = i.pc;
    e.rd         = i.rd;
    e.store_data = i.rs2;
    e.exc_op     = i.exc_op;
    e.csr_addr   = i.csr_addr;
    case (i.exc_op)
      exc_lui:               e.alu_res = up;
      exc_auipc:             e.alu_res = i.pc + up;
      exc_jal, exc_jalr:     e.alu_res = i.pc + 32'd4;
      exc_load, exc_store:   e.alu_res = i.rs1 + i.imm;
      exc_opimm:             e.alu_res = alu_model(i.alu_op, i.rs1, i.imm);
      exc_opreg, exc_branch: e.alu_res = alu_model(i.alu_op, i.rs1, i.rs2);
      exc_csr:               e.alu_res = i.csr_old;
      default:               e.alu_res = 32'h0;
    endcase
    src       = i.csr_use_imm ? {27'b0, i.imm[4:0]} : i.rs1;
    e.csr_new = i.csr_old;
    e.csr_we  = 1'b0;
    case (i.csr_op)
      csr_rw: begin
        e.csr_new = src;
        e.csr_we  = 1'b1;
      end
      csr_rs: begin
        e.csr_new = i.csr_old | src;
        e.csr_we  = (src != 0);
      end
      csr_rc: begin
        e.csr_new = i.csr_old & ~src;
        e.csr_we  = (src != 0);
      end
      default: ;
    endcase
    if (i.exc_op != exc_csr) e.csr_we = 1'b0;
    return e;
  endfunction

  function automatic logic is_ctrl(issue_t i);
    return i.exc_op inside {exc_jal, exc_jalr, exc_branch};
  endfunction

  function automatic logic ctrl_taken(issue_t i);
    return (i.exc_op == exc_jal) || (i.exc_op == exc_jalr) ||
           (i.exc_op == exc_branch && cond_model(i.alu_op, i.rs1, i.rs2));
  endfunction

  function automatic redirect_t redirect_model(logic v, issue_t i);
    redirect_t   r;
    logic [31:0] sum;
    sum     = i.rs1 + i.imm;
    r.valid = v && is_ctrl(i) && (ctrl_taken(i) != i.pdt_taken);
    if (i.pdt_taken && !ctrl_taken(i)) begin
      r.target = i.pc + 32'd4;
    end else if (i.exc_op == exc_jalr) begin
      r.target = {sum[31:1], 1'b0};
    end else begin
      r.target = i.pc + i.imm;
    end
    return r;
  endfunction

  function automatic bpu_update_t bpu_model(logic v, issue_t i);
    bpu_update_t b;
    b.valid       = v && is_ctrl(i);
    b.taken       = ctrl_taken(i);
    b.pc          = i.pc;
    b.pdt_correct = (ctrl_taken(i) == i.pdt_taken);
    case (i.exc_op)
      exc_jal:    b.jump_type = 2'd1;
      exc_jalr:   b.jump_type = 2'd2;
      exc_branch: b.jump_type = 2'd3;
      default:    b.jump_type = 2'd0;
    endcase
    return b;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s at %0t", what, $time);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_result(input ex_result_t got, input ex_result_t exp);
    check_value("result_o.pc", got.pc, exp.pc);
    check_value("result_o.rd", 32'(got.rd), 32'(exp.rd));
    check_value("result_o.alu_res", got.alu_res, exp.alu_res);
    check_value("result_o.store_data", got.store_data, exp.store_data);
    check_value("result_o.exc_op", 32'(got.exc_op), 32'(exp.exc_op));
    check_value("result_o.csr_we", 32'(got.csr_we), 32'(exp.csr_we));
    check_value("result_o.csr_addr", 32'(got.csr_addr), 32'(exp.csr_addr));
    check_value("result_o.csr_new", got.csr_new, exp.csr_new);
  endtask

  // one clock of checks, stimulus and model update
  task automatic run_cycle(input logic feed);
    redirect_t   exp_rd;
    bpu_update_t exp_bpu;
    logic        exp_stall;
    logic        accept;
    logic [31:0] r;
    @(negedge clk);
    if (result_valid && !last_mem_stall) begin
      if (exp_q.size() == 0) stop_with_error("result appeared with nothing outstanding");
      check_result(result, exp_q.pop_front());
    end
    exp_rd  = redirect_model(idex_valid_m, idex_m);
    exp_bpu = bpu_model(idex_valid_m, idex_m);
    check_value("redirect_o.valid", 32'(redirect.valid), 32'(exp_rd.valid));
    if (exp_rd.valid) check_value("redirect_o.target", redirect.target, exp_rd.target);
    check_value("bpu_o.valid", 32'(bpu.valid), 32'(exp_bpu.valid));
    if (exp_bpu.valid) begin
      check_value("bpu_o.taken", 32'(bpu.taken), 32'(exp_bpu.taken));
      check_value("bpu_o.jump_type", 32'(bpu.jump_type), 32'(exp_bpu.jump_type));
      check_value("bpu_o.pc", bpu.pc, exp_bpu.pc);
      check_value("bpu_o.pdt_correct", 32'(bpu.pdt_correct), 32'(exp_bpu.pdt_correct));
    end
    r         = next_rand();
    mem_stall = (r[2:0] < 3'd2);
    if (!held) begin
      issue_valid = feed && (r[5:3] != 3'd0);
      issue       = new_instr(idex_m);
    end
    #1;
    exp_stall = (idex_valid_m && is_muldiv(idex_m) && md_left > 0) || mem_stall;
    check_value("stall_o", 32'(stall), 32'(exp_stall));
    accept = issue_valid && !exp_stall && !exp_rd.valid;  // redirect drops the offer
    held   = issue_valid && exp_stall;
    if (accept) begin
      exp_q.push_back(expected_result(issue));
      accepted++;
    end
    last_mem_stall = mem_stall;
    if (idex_valid_m && is_muldiv(idex_m) && md_left > 0) md_left--;
    if (!exp_stall) begin
      idex_valid_m = accept;
      idex_m       = issue;
      md_left      = `EXU_MULDIV_STEPS;
    end
  endtask

  initial begin
    rst            = 1'b1;
    issue_valid    = 1'b0;
    issue          = '0;
    mem_stall      = 1'b0;
    idex_valid_m   = 1'b0;
    idex_m         = '0;
    md_left        = 0;
    last_mem_stall = 1'b0;
    held           = 1'b0;
    accepted       = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    check_value("result_valid_o", 32'(result_valid), 32'h0);
    check_value("redirect_o.valid", 32'(redirect.valid), 32'h0);
    check_value("bpu_o.valid", 32'(bpu.valid), 32'h0);
    check_value("stall_o", 32'(stall), 32'h0);

    cycles = 0;
    while (accepted < num_instr && cycles < 40000) begin
      run_cycle(1'b1);
      cycles++;
    end
    if (accepted < num_instr) stop_with_error("timeout: instructions were not accepted");

    cycles = 0;
    while ((exp_q.size() != 0 || idex_valid_m) && cycles < 2000) begin
      run_cycle(1'b0);
      cycles++;
    end
    if (exp_q.size() != 0) stop_with_error("timeout: results are missing");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/exu_pkg.sv
logic/stage_reg.sv
logic/alu_top.sv
logic/execute_csr.sv
logic/branch_resolve.sv
logic/exu.sv
logic/ex_stage_top.sv
bench/ex_stage_assertions.sv
bench/ex_stage_tb.sv

// File: include/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// datapath width
`define EXU_XLEN 32

// register file index
`define EXU_REG_AW 5

// immediate as delivered by decode, already sign extended
`define EXU_IMM_W 32

// csr address and the zimm field of csrrwi/csrrsi/csrrci
`define EXU_CSR_AW 12
`define EXU_CSR_IMM_W 5

// one quotient or product bit per cycle
`define EXU_MULDIV_STEPS 32

`endif

// File: logic/alu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module alu_top (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   start_i,
  input  wire exu_pkg::alu_op_e alu_op_i,
  input  wire [`EXU_XLEN-1:0]   a_i,
  input  wire [`EXU_XLEN-1:0]   b_i,
  output logic [`EXU_XLEN-1:0]  result_o,
  output logic                  compare_o,
  output logic                  busy_o
);
  import exu_pkg::*;

  localparam int cnt_w = $clog2(`EXU_MULDIV_STEPS);
  localparam logic [cnt_w-1:0] last_step = cnt_w'(`EXU_MULDIV_STEPS - 1);

  logic                   eq, lt_s, lt_u;
  logic [4:0]             shamt;
  logic [`EXU_XLEN-1:0]   base_res, md_res;
  logic                   is_md, is_div, a_neg, b_neg, div_zero;
  logic [`EXU_XLEN-1:0]   a_mag, b_mag;
  logic [cnt_w-1:0]       cnt_q;
  logic                   done_q, done_hit, md_go;
  logic [`EXU_XLEN-1:0]   hi_q, lo_q, hi_cur, lo_cur, hi_nxt, lo_nxt;
  logic [`EXU_XLEN:0]     mul_sum, div_trial;
  logic [`EXU_XLEN-1:0]   a_q, b_q;
  alu_op_e                op_q;
  logic [2*`EXU_XLEN-1:0] prod;

  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);
  assign shamt = b_i[4:0];

  always_comb begin
    compare_o = 1'b0;
    case (alu_op_i)
      alu_beq:  compare_o = eq;
      alu_bne:  compare_o = ~eq;
      alu_blt:  compare_o = lt_s;
      alu_bge:  compare_o = ~lt_s;
      alu_bltu: compare_o = lt_u;
      alu_bgeu: compare_o = ~lt_u;
      default:  compare_o = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      alu_add:  base_res = a_i + b_i;
      alu_sub:  base_res = a_i - b_i;
      alu_sll:  base_res = a_i << shamt;
      alu_slt:  base_res = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      alu_sltu: base_res = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      alu_xor:  base_res = a_i ^ b_i;
      alu_srl:  base_res = a_i >> shamt;
      alu_sra:  base_res = $signed(a_i) >>> shamt;
      alu_or:   base_res = a_i | b_i;
      alu_and:  base_res = a_i & b_i;
      default:  base_res = {{(`EXU_XLEN-1){1'b0}}, compare_o};  // branch compares
    endcase
  end

  // operands stay put while the id/ex register holds, so signs come from the inputs
  assign is_md    = (alu_op_i inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
                                      alu_div, alu_divu, alu_rem, alu_remu});
  assign is_div   = (alu_op_i inside {alu_div, alu_divu, alu_rem, alu_remu});
  assign a_neg    = (alu_op_i inside {alu_mulh, alu_mulhsu, alu_div, alu_rem}) & a_i[`EXU_XLEN-1];
  assign b_neg    = (alu_op_i inside {alu_mulh, alu_div, alu_rem}) & b_i[`EXU_XLEN-1];
  assign a_mag    = a_neg ? -a_i : a_i;
  assign b_mag    = b_neg ? -b_i : b_i;
  assign div_zero = (b_i == '0);

  // same op and operands as the finished one, the held result still applies
  assign done_hit = done_q && (a_i == a_q) && (b_i == b_q) && (alu_op_i == op_q);
  assign md_go    = start_i && is_md && !done_hit;
  assign busy_o   = md_go;

  // first step seeds from the operands
  assign hi_cur = (cnt_q == '0) ? '0 : hi_q;
  assign lo_cur = (cnt_q == '0) ? (is_div ? a_mag : b_mag) : lo_q;

  assign mul_sum   = {1'b0, hi_cur} + (lo_cur[0] ? {1'b0, a_mag} : '0);
  assign div_trial = {hi_cur, lo_cur[`EXU_XLEN-1]} - {1'b0, b_mag};

  always_comb begin
    if (!is_div) begin
      hi_nxt = mul_sum[`EXU_XLEN:1];  // shift-add, product builds into lo
      lo_nxt = {mul_sum[0], lo_cur[`EXU_XLEN-1:1]};
    end else if (!div_trial[`EXU_XLEN]) begin
      hi_nxt = div_trial[`EXU_XLEN-1:0];
      lo_nxt = {lo_cur[`EXU_XLEN-2:0], 1'b1};
    end else begin
      hi_nxt = {hi_cur[`EXU_XLEN-2:0], lo_cur[`EXU_XLEN-1]};  // restore
      lo_nxt = {lo_cur[`EXU_XLEN-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (md_go) begin
      cnt_q  <= (cnt_q == last_step) ? '0 : cnt_q + 1'b1;
      done_q <= (cnt_q == last_step);
    end else if (!done_hit) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (md_go) begin
      hi_q <= hi_nxt;
      lo_q <= lo_nxt;
      if (cnt_q == last_step) begin
        a_q  <= a_i;
        b_q  <= b_i;
        op_q <= alu_op_i;
      end
    end
  end

  assign prod = (a_neg ^ b_neg) ? -{hi_q, lo_q} : {hi_q, lo_q};

  always_comb begin
    case (alu_op_i)
      alu_mul:                         md_res = prod[`EXU_XLEN-1:0];
      alu_mulh, alu_mulhsu, alu_mulhu: md_res = prod[2*`EXU_XLEN-1:`EXU_XLEN];
      alu_div, alu_divu:               md_res = div_zero ? '1 :
                                                ((a_neg ^ b_neg) ? -lo_q : lo_q);
      default:                         md_res = div_zero ? a_i : (a_neg ? -hi_q : hi_q);
    endcase
  end

  assign result_o = is_md ? md_res : base_res;

endmodule

`default_nettype wire

// File: logic/branch_resolve.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module branch_resolve (
  input  wire exu_pkg::issue_t     issue_i,
  input  wire                      compare_i,
  output exu_pkg::redirect_t       redirect_o,
  output exu_pkg::bpu_update_t     bpu_o
);
  import exu_pkg::*;

  logic                 is_jal, is_jalr, is_br, is_ctrl;
  logic                 taken, mispredict;
  logic [`EXU_XLEN-1:0] jalr_sum;

  assign is_jal  = (issue_i.exc_op == exc_jal);
  assign is_jalr = (issue_i.exc_op == exc_jalr);
  assign is_br   = (issue_i.exc_op == exc_branch);
  assign is_ctrl = is_jal | is_jalr | is_br;

  assign taken      = (is_br & compare_i) | is_jal | is_jalr;  // jumps always go
  assign mispredict = is_ctrl & (taken != issue_i.pdt_taken);

  assign jalr_sum = issue_i.rs1 + issue_i.imm;

  always_comb begin
    redirect_o.valid = mispredict;
    if (issue_i.pdt_taken && !taken) begin
      redirect_o.target = issue_i.pc + `EXU_XLEN'd4;  // fall through
    end else if (is_jalr) begin
      redirect_o.target = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
    end else begin
      redirect_o.target = issue_i.pc + issue_i.imm;
    end
  end

  always_comb begin
    bpu_o.valid       = is_ctrl;
    bpu_o.taken       = taken;
    bpu_o.pc          = issue_i.pc;
    bpu_o.pdt_correct = (taken == issue_i.pdt_taken);
    if (is_jal) begin
      bpu_o.jump_type = 2'd1;
    end else if (is_jalr) begin
      bpu_o.jump_type = 2'd2;
    end else if (is_br) begin
      bpu_o.jump_type = 2'd3;
    end else begin
      bpu_o.jump_type = 2'd0;
    end
  end

endmodule

`default_nettype wire

// File: logic/ex_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_top (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   issue_valid_i,
  input  wire exu_pkg::issue_t  issue_i,
  input  wire                   mem_stall_i,
  output logic                  stall_o,
  output logic                  result_valid_o,
  output exu_pkg::ex_result_t   result_o,
  output exu_pkg::redirect_t    redirect_o,
  output exu_pkg::bpu_update_t  bpu_o
);
  import exu_pkg::*;

  issue_t     idex_data;
  logic       idex_valid;
  ex_result_t ex_res;
  logic       ex_busy;
  logic       flush_idex;

  assign stall_o = ex_busy | mem_stall_i;

  // wrong-path instruction offered alongside the redirect is dropped
  assign flush_idex = redirect_o.valid & ~stall_o;

  stage_reg #(
    .payload_t (issue_t)
  ) u_idex (
    .clk     (clk),
    .rst_i   (rst_i),
    .hold_i  (stall_o),
    .flush_i (flush_idex),
    .valid_i (issue_valid_i),
    .data_i  (issue_i),
    .valid_o (idex_valid),
    .data_o  (idex_data)
  );

  exu u_exu (
    .clk        (clk),
    .rst_i      (rst_i),
    .valid_i    (idex_valid),
    .issue_i    (idex_data),
    .result_o   (ex_res),
    .redirect_o (redirect_o),
    .bpu_o      (bpu_o),
    .busy_o     (ex_busy)
  );

  // memory stall holds, a busy mul/div only inserts bubbles
  stage_reg #(
    .payload_t (ex_result_t)
  ) u_exmem (
    .clk     (clk),
    .rst_i   (rst_i),
    .hold_i  (mem_stall_i),
    .flush_i (ex_busy),
    .valid_i (idex_valid),
    .data_i  (ex_res),
    .valid_o (result_valid_o),
    .data_o  (result_o)
  );

endmodule

`default_nettype wire

// File: logic/execute_csr.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module execute_csr (
  input  wire exu_pkg::csr_op_e       csr_op_i,
  input  wire                         use_imm_i,
  input  wire [`EXU_CSR_IMM_W-1:0]    csr_imm_i,
  input  wire [`EXU_XLEN-1:0]         rs1_i,
  input  wire [`EXU_XLEN-1:0]         csr_old_i,
  output logic [`EXU_XLEN-1:0]        csr_new_o,
  output logic                        csr_we_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] src;
  logic                 src_zero;

  assign src = use_imm_i ? {{(`EXU_XLEN-`EXU_CSR_IMM_W){1'b0}}, csr_imm_i} : rs1_i;
  assign src_zero = (src == '0);

  always_comb begin
    csr_new_o = csr_old_i;
    csr_we_o  = 1'b0;
    case (csr_op_i)
      csr_rw: begin
        csr_new_o = src;
        csr_we_o  = 1'b1;
      end
      csr_rs: begin
        csr_new_o = csr_old_i | src;   // set bits
        csr_we_o  = ~src_zero;         // zero source is a pure read
      end
      csr_rc: begin
        csr_new_o = csr_old_i & ~src;  // clear bits
        csr_we_o  = ~src_zero;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/exu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   valid_i,
  input  wire exu_pkg::issue_t  issue_i,
  output exu_pkg::ex_result_t   result_o,
  output exu_pkg::redirect_t    redirect_o,
  output exu_pkg::bpu_update_t  bpu_o,
  output logic                  busy_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] op_a, op_b, upper_imm, alu_res, csr_new;
  logic                 compare, csr_we;
  alu_op_e              alu_op;
  redirect_t            br_redirect;
  bpu_update_t          br_bpu;

  assign upper_imm = {issue_i.imm[`EXU_XLEN-1:12], 12'b0};

  always_comb begin
    op_a   = '0;
    op_b   = '0;
    alu_op = alu_add;  // address and link math all add
    case (issue_i.exc_op)
      exc_opreg, exc_branch: begin
        op_a   = issue_i.rs1;
        op_b   = issue_i.rs2;
        alu_op = issue_i.alu_op;
      end
      exc_opimm, exc_load, exc_store: begin
        op_a   = issue_i.rs1;
        op_b   = issue_i.imm;
        alu_op = (issue_i.exc_op == exc_opimm) ? issue_i.alu_op : alu_add;
      end
      exc_jal, exc_jalr: begin
        op_a = issue_i.pc;
        op_b = `EXU_XLEN'd4;  // link value
      end
      exc_auipc: begin
        op_a = issue_i.pc;
        op_b = upper_imm;
      end
      exc_lui: op_b = upper_imm;
      exc_csr: op_b = issue_i.csr_old;  // rd gets the old csr value
      default: ;
    endcase
  end

  alu_top u_alu (
    .clk       (clk),
    .rst_i     (rst_i),
    .start_i   (valid_i),
    .alu_op_i  (alu_op),
    .a_i       (op_a),
    .b_i       (op_b),
    .result_o  (alu_res),
    .compare_o (compare),
    .busy_o    (busy_o)
  );

  execute_csr u_csr (
    .csr_op_i  (issue_i.csr_op),
    .use_imm_i (issue_i.csr_use_imm),
    .csr_imm_i (issue_i.imm[`EXU_CSR_IMM_W-1:0]),
    .rs1_i     (issue_i.rs1),
    .csr_old_i (issue_i.csr_old),
    .csr_new_o (csr_new),
    .csr_we_o  (csr_we)
  );

  branch_resolve u_branch (
    .issue_i    (issue_i),
    .compare_i  (compare),
    .redirect_o (br_redirect),
    .bpu_o      (br_bpu)
  );

  always_comb begin
    result_o.pc         = issue_i.pc;
    result_o.rd         = issue_i.rd;
    result_o.alu_res    = alu_res;
    result_o.store_data = issue_i.rs2;
    result_o.exc_op     = issue_i.exc_op;
    result_o.csr_we     = csr_we & (issue_i.exc_op == exc_csr);
    result_o.csr_addr   = issue_i.csr_addr;
    result_o.csr_new    = csr_new;

    redirect_o       = br_redirect;
    redirect_o.valid = br_redirect.valid & valid_i;  // bubbles never redirect
    bpu_o            = br_bpu;
    bpu_o.valid      = br_bpu.valid & valid_i;
  end

endmodule

`default_nettype wire

// File: logic/exu_pkg.sv
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

  // instruction class from decode
  typedef enum logic [3:0] {
    exc_none, exc_lui, exc_auipc, exc_jal, exc_jalr, exc_branch,
    exc_load, exc_store, exc_opimm, exc_opreg, exc_csr
  } exc_op_e;

  // alu function, mul/div group kept last
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    alu_mul, alu_mulh, alu_mulhsu, alu_mulhu, alu_div, alu_divu, alu_rem, alu_remu
  } alu_op_e;

  typedef enum logic [1:0] {
    csr_none, csr_rw, csr_rs, csr_rc
  } csr_op_e;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]   pc;
    logic [`EXU_REG_AW-1:0] rd;
    logic [`EXU_XLEN-1:0]   rs1;
    logic [`EXU_XLEN-1:0]   rs2;
    logic [`EXU_IMM_W-1:0]  imm;        // zimm sits in the low bits for csr*i
    exc_op_e                exc_op;
    alu_op_e                alu_op;
    csr_op_e                csr_op;
    logic [`EXU_CSR_AW-1:0] csr_addr;
    logic [`EXU_XLEN-1:0]   csr_old;    // value read from the csr file
    logic                   csr_use_imm;
    logic                   pdt_taken;  // predicted direction
  } issue_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]   pc;
    logic [`EXU_REG_AW-1:0] rd;
    logic [`EXU_XLEN-1:0]   alu_res;
    logic [`EXU_XLEN-1:0]   store_data;
    exc_op_e                exc_op;
    logic                   csr_we;
    logic [`EXU_CSR_AW-1:0] csr_addr;
    logic [`EXU_XLEN-1:0]   csr_new;
  } ex_result_t;

  typedef struct packed {
    logic                 valid;
    logic [`EXU_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                 valid;
    logic                 taken;
    logic [1:0]           jump_type;   // 1 jal, 2 jalr, 3 branch
    logic [`EXU_XLEN-1:0] pc;
    logic                 pdt_correct;
  } bpu_update_t;

endpackage

`default_nettype wire

// File: logic/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  wire           clk,
  input  wire           rst_i,
  input  wire           hold_i,
  input  wire           flush_i,
  input  wire           valid_i,
  input  wire payload_t data_i,
  output logic          valid_o,
  output payload_t      data_o
);

  // hold wins over flush, a held stage keeps its instruction
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (!hold_i) begin
      valid_o <= valid_i & ~flush_i;  // flush turns the slot into a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire
